// File: common/chan_view_if.sv
//----------------------------
// Register state of one DMA channel.
// Read by the readback mux and copied to the top-level ports.
//----------------------------
`timescale 1ns/1ps
`default_nettype none

interface chan_view_if;

    logic        start;
    logic        relaxed;
    logic        nosnoop;
    logic [31:0] size;       // Bytes
    logic [31:0] addr;
    logic [7:0]  up_addr;
    logic [2:0]  tc;
    logic        en64;
    logic        phant_dis;
    logic [31:0] perf;       // Busy cycles
    logic        done_clr;

    modport chan (
        output start, relaxed, nosnoop, size, addr, up_addr, tc,
        output en64, phant_dis, perf, done_clr
    );

    modport result (
        input start, relaxed, nosnoop, size, addr, up_addr, tc,
        input en64, phant_dis, perf, done_clr
    );

endinterface

`default_nettype wire

// File: common/chan_wr_if.sv
//----------------------------
// Write path from address decode into one DMA channel.
// Strobes are single-cycle and sampled on the same edge.
//----------------------------
`timescale 1ns/1ps
`default_nettype none

interface chan_wr_if;
    import dma_ctrl_pkg::*;

    logic       wr_ctrl;     // Control word written
    logic       wr_size;
    logic       wr_addr;
    logic       wr_upaddr;
    chan_ctrl_t ctrl;        // This channel's half, reserved bits cleared
    dma_wdata_u wdata;

    modport decode (
        output wr_ctrl, wr_size, wr_addr, wr_upaddr, ctrl, wdata
    );

    modport chan (
        input wr_ctrl, wr_size, wr_addr, wr_upaddr, ctrl, wdata
    );

endinterface

`default_nettype wire

// File: common/dma_ctrl_pkg.sv
//----------------------------
// Shared definitions for the DMA control register block.
// Holds widths, the register map, the ID constants and the
// layouts of one 32-bit register word. Import it inside the
// module body, or use scoped names in port lists.
//----------------------------
`default_nettype none

package dma_ctrl_pkg;

    localparam int DATA_W     = 32;
    localparam int REG_ADDR_W = 7;   // Word index, 128 registers
    localparam int LEN_W      = 16;
    localparam int MPS_W      = 3;

    // Register map --------------
    localparam logic [REG_ADDR_W-1:0] REG_ID       = 7'd0;
    localparam logic [REG_ADDR_W-1:0] REG_CTRL     = 7'd1;
    localparam logic [REG_ADDR_W-1:0] REG_LEN      = 7'd3;
    localparam logic [REG_ADDR_W-1:0] REG_MRD_SIZE = 7'd4;
    localparam logic [REG_ADDR_W-1:0] REG_MWR_SIZE = 7'd5;
    localparam logic [REG_ADDR_W-1:0] REG_MRD_ADDR = 7'd6;
    localparam logic [REG_ADDR_W-1:0] REG_MWR_ADDR = 7'd7;
    localparam logic [REG_ADDR_W-1:0] REG_MRD_UP   = 7'd8;
    localparam logic [REG_ADDR_W-1:0] REG_MWR_UP   = 7'd9;
    localparam logic [REG_ADDR_W-1:0] REG_MRD_PERF = 7'd10;
    localparam logic [REG_ADDR_W-1:0] REG_MWR_PERF = 7'd11;

    localparam logic [7:0]       VERSION_NUMBER = 8'h16;
    localparam logic [LEN_W-1:0] MRD_LEN_DW     = 16'd32;  // Fixed read request, dwords

    // One channel's half of the control word
    typedef struct packed {
        logic [6:0] rsvd_hi;
        logic       done;     // Status only, never written
        logic       rsvd_7;
        logic       nosnoop;
        logic       relaxed;
        logic [3:0] rsvd_lo;
        logic       start;
    } chan_ctrl_t;

    typedef struct packed {
        chan_ctrl_t mrd;      // Upper half
        chan_ctrl_t mwr;      // Lower half
    } ctrl_pair_t;

    typedef struct packed {
        logic [7:0]  up_addr;
        logic [2:0]  rsvd_hi;
        logic        phant_dis;
        logic        en64;
        logic [2:0]  tc;
        logic [15:0] rsvd_lo;
    } up_fields_t;

    // Same word seen as control pair or as upper-address fields
    typedef union packed {
        logic [DATA_W-1:0] raw;
        ctrl_pair_t        ctrl;
        up_fields_t        up;
    } dma_wdata_u;

endpackage

`default_nettype wire

// File: design/dma_channel/dma_channel.sv
//----------------------------
// One DMA channel: descriptor registers, done-clear pulse
// and busy-cycle counter. Instantiated once per direction.
//----------------------------
`timescale 1ns/1ps
`default_nettype none

module dma_channel (
    input  wire logic  clk,
    input  wire logic  rst_n,
    input  wire logic  init_rst_i,
    input  wire logic  done_i,
    chan_wr_if.chan    wr,
    chan_view_if.chan  view
);

    logic        start_q;
    logic        relaxed_q;
    logic        nosnoop_q;
    logic [31:0] size_q;
    logic [31:0] addr_q;
    logic [7:0]  up_addr_q;
    logic [2:0]  tc_q;
    logic        en64_q;
    logic        phant_dis_q;
    logic        start_prev;
    logic        done_clr_q;
    logic [31:0] perf_q;

    // Descriptor ----------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            start_q     <= 1'b0;
            relaxed_q   <= 1'b0;
            nosnoop_q   <= 1'b0;
            size_q      <= '0;
            addr_q      <= '0;
            up_addr_q   <= '0;
            tc_q        <= '0;
            en64_q      <= 1'b0;
            phant_dis_q <= 1'b0;
        end else begin
            if (wr.wr_ctrl) begin
                start_q   <= wr.ctrl.start;
                relaxed_q <= wr.ctrl.relaxed;
                nosnoop_q <= wr.ctrl.nosnoop;
            end
            if (wr.wr_size)
                size_q <= wr.wdata.raw;
            if (wr.wr_addr)
                addr_q <= wr.wdata.raw;
            if (wr.wr_upaddr) begin
                up_addr_q   <= wr.wdata.up.up_addr;
                tc_q        <= wr.wdata.up.tc;
                en64_q      <= wr.wdata.up.en64;
                phant_dis_q <= wr.wdata.up.phant_dis;
            end
        end
    end

    // Falling start gives a one-cycle done clear
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            start_prev <= 1'b0;
            done_clr_q <= 1'b0;
        end else begin
            start_prev <= start_q;
            done_clr_q <= start_prev && !start_q;
        end
    end

    // Performance counter -------
    always_ff @(posedge clk) begin
        if (!rst_n)
            perf_q <= '0;
        else if (init_rst_i || done_clr_q)
            perf_q <= '0;
        else if (start_q && !done_i)
            perf_q <= perf_q + 32'd1;   // Still busy
    end

    assign view.start     = start_q;
    assign view.relaxed   = relaxed_q;
    assign view.nosnoop   = nosnoop_q;
    assign view.size      = size_q;
    assign view.addr      = addr_q;
    assign view.up_addr   = up_addr_q;
    assign view.tc        = tc_q;
    assign view.en64      = en64_q;
    assign view.phant_dis = phant_dis_q;
    assign view.perf      = perf_q;
    assign view.done_clr  = done_clr_q;

endmodule

`default_nettype wire

// File: design/dma_ctrl_regs.sv
//----------------------------
// DMA control register block of the PCIe endpoint.
// Host side is a word-addressed port with one-cycle read latency.
// Drives the descriptors of the memory-read and memory-write
// channels to the DMA engine.
//----------------------------
`timescale 1ns/1ps
`default_nettype none

module dma_ctrl_regs #(
    parameter logic [3:0] INTERFACE_TYPE = 4'h2,
    parameter logic [7:0] FPGA_FAMILY    = 8'h14
) (
    input  wire logic                               clk,
    input  wire logic                               rst_n,
    input  wire logic                               en_i,
    input  wire logic [dma_ctrl_pkg::REG_ADDR_W-1:0] a_i,
    input  wire logic                               wr_en_i,
    input  wire logic [dma_ctrl_pkg::DATA_W-1:0]    wr_d_i,
    input  wire logic [dma_ctrl_pkg::MPS_W-1:0]     cfg_prg_max_payload_size_i,
    input  wire logic                               mrd_done_i,
    input  wire logic                               mwr_done_i,
    output logic [dma_ctrl_pkg::DATA_W-1:0]         rd_d_o,
    output logic                                    init_rst_o,
    output logic [dma_ctrl_pkg::LEN_W-1:0]          mwr_len_o,
    // Memory read channel
    output logic                                    mrd_start_o,
    output logic [31:0]                             mrd_addr_o,
    output logic [31:0]                             mrd_size_o,
    output logic [7:0]                              mrd_up_addr_o,
    output logic [2:0]                              mrd_tlp_tc_o,
    output logic                                    mrd_64b_en_o,
    output logic                                    mrd_phant_func_dis1_o,
    output logic                                    mrd_relaxed_order_o,
    output logic                                    mrd_nosnoop_o,
    output logic                                    mrd_done_clr_o,
    // Memory write channel
    output logic                                    mwr_start_o,
    output logic [31:0]                             mwr_addr_o,
    output logic [31:0]                             mwr_size_o,
    output logic [7:0]                              mwr_up_addr_o,
    output logic [2:0]                              mwr_tlp_tc_o,
    output logic                                    mwr_64b_en_o,
    output logic                                    mwr_phant_func_dis1_o,
    output logic                                    mwr_relaxed_order_o,
    output logic                                    mwr_nosnoop_o,
    output logic                                    mwr_done_clr_o
);

    chan_wr_if   mrd_wr ();
    chan_wr_if   mwr_wr ();
    chan_view_if mrd_view ();
    chan_view_if mwr_view ();

    reg_decode u_decode (
        .clk                        (clk),
        .rst_n                      (rst_n),
        .en_i                       (en_i),
        .a_i                        (a_i),
        .wr_en_i                    (wr_en_i),
        .wr_d_i                     (wr_d_i),
        .cfg_prg_max_payload_size_i (cfg_prg_max_payload_size_i),
        .mrd_wr                     (mrd_wr.decode),
        .mwr_wr                     (mwr_wr.decode),
        .init_rst_o                 (init_rst_o),
        .mwr_len_o                  (mwr_len_o)
    );

    dma_channel u_mrd_chan (
        .clk        (clk),
        .rst_n      (rst_n),
        .init_rst_i (init_rst_o),
        .done_i     (mrd_done_i),
        .wr         (mrd_wr.chan),
        .view       (mrd_view.chan)
    );

    dma_channel u_mwr_chan (
        .clk        (clk),
        .rst_n      (rst_n),
        .init_rst_i (init_rst_o),
        .done_i     (mwr_done_i),
        .wr         (mwr_wr.chan),
        .view       (mwr_view.chan)
    );

    readback_mux #(
        .INTERFACE_TYPE (INTERFACE_TYPE),
        .FPGA_FAMILY    (FPGA_FAMILY)
    ) u_readback (
        .clk        (clk),
        .rst_n      (rst_n),
        .a_i        (a_i),
        .init_rst_i (init_rst_o),
        .mwr_len_i  (mwr_len_o),
        .mrd_done_i (mrd_done_i),
        .mwr_done_i (mwr_done_i),
        .mrd_view   (mrd_view.result),
        .mwr_view   (mwr_view.result),
        .rd_d_o     (rd_d_o)
    );

    // Channel state out to the DMA engine ----------
    assign mrd_start_o           = mrd_view.start;
    assign mrd_addr_o            = mrd_view.addr;
    assign mrd_size_o            = mrd_view.size;
    assign mrd_up_addr_o         = mrd_view.up_addr;
    assign mrd_tlp_tc_o          = mrd_view.tc;
    assign mrd_64b_en_o          = mrd_view.en64;
    assign mrd_phant_func_dis1_o = mrd_view.phant_dis;
    assign mrd_relaxed_order_o   = mrd_view.relaxed;
    assign mrd_nosnoop_o         = mrd_view.nosnoop;
    assign mrd_done_clr_o        = mrd_view.done_clr;

    assign mwr_start_o           = mwr_view.start;
    assign mwr_addr_o            = mwr_view.addr;
    assign mwr_size_o            = mwr_view.size;
    assign mwr_up_addr_o         = mwr_view.up_addr;
    assign mwr_tlp_tc_o          = mwr_view.tc;
    assign mwr_64b_en_o          = mwr_view.en64;
    assign mwr_phant_func_dis1_o = mwr_view.phant_dis;
    assign mwr_relaxed_order_o   = mwr_view.relaxed;
    assign mwr_nosnoop_o         = mwr_view.nosnoop;
    assign mwr_done_clr_o        = mwr_view.done_clr;

endmodule

`default_nettype wire

// File: design/readback_mux.sv
//----------------------------
// Registered read data for the host port.
// rd_d_o shows the addressed register one cycle after the address,
// with the value from before any write in that same cycle.
//----------------------------
`timescale 1ns/1ps
`default_nettype none

module readback_mux #(
    parameter logic [3:0] INTERFACE_TYPE = 4'h2,
    parameter logic [7:0] FPGA_FAMILY    = 8'h14
) (
    input  wire logic                                clk,
    input  wire logic                                rst_n,
    input  wire logic [dma_ctrl_pkg::REG_ADDR_W-1:0] a_i,
    input  wire logic                                init_rst_i,
    input  wire logic [dma_ctrl_pkg::LEN_W-1:0]      mwr_len_i,
    input  wire logic                                mrd_done_i,
    input  wire logic                                mwr_done_i,
    chan_view_if.result                              mrd_view,
    chan_view_if.result                              mwr_view,
    output logic [dma_ctrl_pkg::DATA_W-1:0]          rd_d_o
);
    import dma_ctrl_pkg::*;

    dma_wdata_u rd_next;

    function automatic chan_ctrl_t ctrl_half(
        input logic start,
        input logic relaxed,
        input logic nosnoop,
        input logic done
    );
        chan_ctrl_t c;
        c         = '0;
        c.start   = start;
        c.relaxed = relaxed;
        c.nosnoop = nosnoop;
        c.done    = done;
        return c;
    endfunction

    function automatic dma_wdata_u up_word(
        input logic [7:0] up_addr,
        input logic       phant_dis,
        input logic       en64,
        input logic [2:0] tc
    );
        dma_wdata_u w;
        w              = '0;
        w.up.up_addr   = up_addr;
        w.up.phant_dis = phant_dis;
        w.up.en64      = en64;
        w.up.tc        = tc;
        return w;
    endfunction

    always_comb begin
        rd_next = '0;   // Reserved indices read zero
        case (a_i)
            REG_ID:       rd_next.raw = {FPGA_FAMILY, 4'h0, INTERFACE_TYPE,
                                         VERSION_NUMBER, 7'h0, init_rst_i};
            REG_CTRL: begin
                rd_next.ctrl.mrd = ctrl_half(mrd_view.start, mrd_view.relaxed,
                                             mrd_view.nosnoop, mrd_done_i);
                rd_next.ctrl.mwr = ctrl_half(mwr_view.start, mwr_view.relaxed,
                                             mwr_view.nosnoop, mwr_done_i);
            end
            REG_LEN:      rd_next.raw = {MRD_LEN_DW, mwr_len_i};
            REG_MRD_SIZE: rd_next.raw = mrd_view.size;
            REG_MWR_SIZE: rd_next.raw = mwr_view.size;
            REG_MRD_ADDR: rd_next.raw = mrd_view.addr;
            REG_MWR_ADDR: rd_next.raw = mwr_view.addr;
            REG_MRD_UP:   rd_next = up_word(mrd_view.up_addr, mrd_view.phant_dis,
                                            mrd_view.en64, mrd_view.tc);
            REG_MWR_UP:   rd_next = up_word(mwr_view.up_addr, mwr_view.phant_dis,
                                            mwr_view.en64, mwr_view.tc);
            REG_MRD_PERF: rd_next.raw = mrd_view.perf;
            REG_MWR_PERF: rd_next.raw = mwr_view.perf;
            default:      rd_next = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n)
            rd_d_o <= '0;
        else
            rd_d_o <= rd_next.raw;
    end

endmodule

`default_nettype wire

// File: design/reg_decode.sv
//----------------------------
// Host write decode.
// Turns address and write enable into per-channel strobes,
// and registers the initiator reset and the write length.
//----------------------------
`timescale 1ns/1ps
`default_nettype none

module reg_decode (
    input  wire logic                                clk,
    input  wire logic                                rst_n,
    input  wire logic                                en_i,
    input  wire logic [dma_ctrl_pkg::REG_ADDR_W-1:0] a_i,
    input  wire logic                                wr_en_i,
    input  wire logic [dma_ctrl_pkg::DATA_W-1:0]     wr_d_i,
    input  wire logic [dma_ctrl_pkg::MPS_W-1:0]      cfg_prg_max_payload_size_i,
    chan_wr_if.decode                                mrd_wr,
    chan_wr_if.decode                                mwr_wr,
    output logic                                     init_rst_o,
    output logic [dma_ctrl_pkg::LEN_W-1:0]           mwr_len_o
);
    import dma_ctrl_pkg::*;

    dma_wdata_u       wd;
    logic [MPS_W-1:0] mps_code;
    logic [LEN_W-1:0] payload_bytes;

    // Keep only the writable control bits
    function automatic chan_ctrl_t clean_ctrl(input chan_ctrl_t c);
        chan_ctrl_t r;
        r         = '0;
        r.start   = c.start;
        r.relaxed = c.relaxed;
        r.nosnoop = c.nosnoop;
        return r;
    endfunction

    assign wd = dma_wdata_u'(wr_d_i);

    // Strobes -------------------
    assign mrd_wr.wr_ctrl   = wr_en_i && (a_i == REG_CTRL);
    assign mrd_wr.wr_size   = wr_en_i && (a_i == REG_MRD_SIZE);
    assign mrd_wr.wr_addr   = wr_en_i && (a_i == REG_MRD_ADDR);
    assign mrd_wr.wr_upaddr = wr_en_i && (a_i == REG_MRD_UP);
    assign mrd_wr.ctrl      = clean_ctrl(wd.ctrl.mrd);
    assign mrd_wr.wdata     = wd;

    assign mwr_wr.wr_ctrl   = wr_en_i && (a_i == REG_CTRL);
    assign mwr_wr.wr_size   = wr_en_i && (a_i == REG_MWR_SIZE);
    assign mwr_wr.wr_addr   = wr_en_i && (a_i == REG_MWR_ADDR);
    assign mwr_wr.wr_upaddr = wr_en_i && (a_i == REG_MWR_UP);
    assign mwr_wr.ctrl      = clean_ctrl(wd.ctrl.mwr);
    assign mwr_wr.wdata     = wd;

    // Codes 6 and 7 are reserved, treated as 128 bytes
    assign mps_code      = (cfg_prg_max_payload_size_i > 3'd5) ? '0 : cfg_prg_max_payload_size_i;
    assign payload_bytes = LEN_W'(128) << mps_code;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            init_rst_o <= 1'b0;
            mwr_len_o  <= '0;
        end else begin
            init_rst_o <= !en_i;
            mwr_len_o  <= payload_bytes >> 2;  // Bytes to dwords
        end
    end

endmodule

`default_nettype wire

// File: dma_ctrl_regs.f
common/dma_ctrl_pkg.sv
common/chan_wr_if.sv
common/chan_view_if.sv
design/dma_channel/dma_channel.sv
design/reg_decode.sv
design/readback_mux.sv
design/dma_ctrl_regs.sv
verification/dma_ctrl_regs_sva.sv
verification/tb_dma_ctrl_regs.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    --top-module tb_dma_ctrl_regs -f dma_ctrl_regs.f \
    && ./obj_dir/Vtb_dma_ctrl_regs > sim.log 2>&1

cat sim.log 2>/dev/null
grep -q "SIMULATION PASSED" sim.log 2>/dev/null \
    && echo "Run passed" \
    || { echo "Run failed, see sim.log"; exit 1; }

// File: verification/dma_ctrl_regs_sva.sv
//----------------------------
// Protocol checks for the DMA control register block.
// Bound to dma_ctrl_regs from the testbench.
//----------------------------
`timescale 1ns/1ps
`default_nettype none

module dma_ctrl_regs_sva (
    input wire logic        clk,
    input wire logic        rst_n,
    input wire logic        en_i,
    input wire logic        init_rst_i,
    input wire logic        mrd_done_clr_i,
    input wire logic        mwr_done_clr_i,
    input wire logic        mrd_size_wr_i,
    input wire logic        mwr_size_wr_i,
    input wire logic [31:0] mrd_size_i,
    input wire logic [31:0] mwr_size_i
);

    // Done clear is a single-cycle pulse
    a_mrd_clr_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        mrd_done_clr_i |=> !mrd_done_clr_i)
        else $error("mrd done clear held longer than one cycle");

    a_mwr_clr_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        mwr_done_clr_i |=> !mwr_done_clr_i)
        else $error("mwr done clear held longer than one cycle");

    // A size write leaves the other channel's size register alone
    a_mrd_size_only: assert property (@(posedge clk) disable iff (!rst_n)
        mrd_size_wr_i |=> $stable(mwr_size_i))
        else $error("mrd size write also changed the mwr size register");

    a_mwr_size_only: assert property (@(posedge clk) disable iff (!rst_n)
        mwr_size_wr_i |=> $stable(mrd_size_i))
        else $error("mwr size write also changed the mrd size register");

    a_init_rst: assert property (@(posedge clk) disable iff (!rst_n)
        $past(rst_n) |-> (init_rst_i == !$past(en_i)))
        else $error("initiator reset does not follow inverted enable");

endmodule

`default_nettype wire

// File: verification/tb_dma_ctrl_regs.sv
//----------------------------
// Testbench for the DMA control register block.
// Random host accesses from a fixed seed, checked every cycle
// against a register model kept in the testbench.
//----------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_dma_ctrl_regs;
    import dma_ctrl_pkg::*;

    localparam int         MRD    = 0;
    localparam int         MWR    = 1;
    localparam logic [7:0] FAMILY = 8'h5a;
    localparam logic [3:0] ITYPE  = 4'h9;

    logic        clk = 1'b0;
    logic        rst_n, en, we;
    logic [6:0]  a;
    logic [31:0] d;
    logic [2:0]  mps;
    logic [1:0]  done_in;
    logic [31:0] rd_d_o;
    logic        init_rst_o;
    logic [15:0] mwr_len_o;
    logic        mrd_start_o, mwr_start_o, mrd_done_clr_o, mwr_done_clr_o;

    // Channel outputs, indexed by MRD and MWR
    logic [1:0][31:0] addr_out;
    logic [1:0][31:0] size_out;
    logic [1:0][7:0]  up_addr_out;
    logic [1:0][2:0]  tc_out;
    logic [1:0]       en64_out;
    logic [1:0]       pfd_out;
    logic [1:0]       relaxed_out;
    logic [1:0]       nosnoop_out;

    // Register model ------------
    logic [1:0]  m_start, m_rel, m_ns, m_prev, m_clr;
    logic [31:0] m_size [2];
    logic [31:0] m_addr [2];
    logic [31:0] m_up [2];
    logic [31:0] m_perf [2];
    logic        m_init;
    logic [15:0] m_len;
    logic [31:0] m_rd;
    integer      seed;
    string       test_name;

    always #20 clk = ~clk;

    dma_ctrl_regs #(.INTERFACE_TYPE(ITYPE), .FPGA_FAMILY(FAMILY)) u_dut (
        .clk(clk), .rst_n(rst_n), .en_i(en), .a_i(a), .wr_en_i(we), .wr_d_i(d),
        .cfg_prg_max_payload_size_i(mps),
        .mrd_done_i(done_in[MRD]), .mwr_done_i(done_in[MWR]),
        .rd_d_o(rd_d_o), .init_rst_o(init_rst_o), .mwr_len_o(mwr_len_o),
        .mrd_start_o(mrd_start_o),
        .mrd_addr_o(addr_out[MRD]),
        .mrd_size_o(size_out[MRD]),
        .mrd_up_addr_o(up_addr_out[MRD]),
        .mrd_tlp_tc_o(tc_out[MRD]),
        .mrd_64b_en_o(en64_out[MRD]),
        .mrd_phant_func_dis1_o(pfd_out[MRD]),
        .mrd_relaxed_order_o(relaxed_out[MRD]),
        .mrd_nosnoop_o(nosnoop_out[MRD]),
        .mrd_done_clr_o(mrd_done_clr_o),
        .mwr_start_o(mwr_start_o),
        .mwr_addr_o(addr_out[MWR]),
        .mwr_size_o(size_out[MWR]),
        .mwr_up_addr_o(up_addr_out[MWR]),
        .mwr_tlp_tc_o(tc_out[MWR]),
        .mwr_64b_en_o(en64_out[MWR]),
        .mwr_phant_func_dis1_o(pfd_out[MWR]),
        .mwr_relaxed_order_o(relaxed_out[MWR]),
        .mwr_nosnoop_o(nosnoop_out[MWR]),
        .mwr_done_clr_o(mwr_done_clr_o)
    );

    bind dma_ctrl_regs dma_ctrl_regs_sva u_sva (
        .clk(clk), .rst_n(rst_n), .en_i(en_i), .init_rst_i(init_rst_o),
        .mrd_done_clr_i(mrd_done_clr_o), .mwr_done_clr_i(mwr_done_clr_o),
        .mrd_size_wr_i(mrd_wr.wr_size), .mwr_size_wr_i(mwr_wr.wr_size),
        .mrd_size_i(mrd_view.size), .mwr_size_i(mwr_view.size)
    );

    task automatic report_mismatch(input string what, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("[ERROR] %s %s: expected %h, actual %h", test_name, what, exp, act);
        $display("SIMULATION FAILED");
        $fatal(1, "Mismatch against the register model");
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout in %s: %s never arrived", test_name, what);
        $display("SIMULATION FAILED");
        $fatal(1, "Wait timed out");
    endtask

    task automatic check_eq(input string what, input logic [31:0] exp,
                            input logic [31:0] act);
        assert (act === exp) else report_mismatch(what, exp, act);
    endtask

    // Read value the model expects for an index
    function automatic logic [31:0] exp_word(input logic [6:0] idx);
        logic [31:0] w;
        w = 32'h0;
        case (idx)
            REG_ID:       w = {FAMILY, 4'h0, ITYPE, 8'h16, 7'h0, m_init};
            REG_CTRL:     w = {7'h0, done_in[MRD], 1'b0, m_ns[MRD], m_rel[MRD], 4'h0,
                               m_start[MRD], 7'h0, done_in[MWR], 1'b0, m_ns[MWR],
                               m_rel[MWR], 4'h0, m_start[MWR]};
            REG_LEN:      w = {16'd32, m_len};
            REG_MRD_SIZE: w = m_size[MRD];
            REG_MWR_SIZE: w = m_size[MWR];
            REG_MRD_ADDR: w = m_addr[MRD];
            REG_MWR_ADDR: w = m_addr[MWR];
            REG_MRD_UP:   w = m_up[MRD];
            REG_MWR_UP:   w = m_up[MWR];
            REG_MRD_PERF: w = m_perf[MRD];
            REG_MWR_PERF: w = m_perf[MWR];
            default:      w = 32'h0;
        endcase
        return w;
    endfunction

    task automatic model_write();
        case (a)
            REG_CTRL: begin
                m_start[MRD] = d[16];
                m_rel[MRD]   = d[21];
                m_ns[MRD]    = d[22];
                m_start[MWR] = d[0];
                m_rel[MWR]   = d[5];
                m_ns[MWR]    = d[6];
            end
            REG_MRD_SIZE: m_size[MRD] = d;
            REG_MWR_SIZE: m_size[MWR] = d;
            REG_MRD_ADDR: m_addr[MRD] = d;
            REG_MWR_ADDR: m_addr[MWR] = d;
            REG_MRD_UP:   m_up[MRD] = d & 32'hff1f_0000;  // Upper byte, PFD, 64b, TC
            REG_MWR_UP:   m_up[MWR] = d & 32'hff1f_0000;
            default:      ;
        endcase
    endtask

    task automatic model_reset();
        m_start = '0;
        m_rel   = '0;
        m_ns    = '0;
        m_prev  = '0;
        m_clr   = '0;
        m_init  = 1'b0;
        m_len   = '0;
        m_rd    = '0;
        for (int c = 0; c < 2; c++) begin
            m_size[c] = '0;
            m_addr[c] = '0;
            m_up[c]   = '0;
            m_perf[c] = '0;
        end
    endtask

    // Advance DUT and model by one clock edge and compare
    task automatic step();
        logic [31:0] rd_n;
        logic [15:0] len_n;
        logic [1:0]  clr_n;
        logic [31:0] perf_n [2];
        string       pfx;
        rd_n  = exp_word(a);
        len_n = (mps > 3'd5) ? 16'd32 : 16'((32'd128 << mps) / 32'd4);
        for (int c = 0; c < 2; c++) begin
            clr_n[c] = m_prev[c] && !m_start[c];
            if (m_init || m_clr[c])
                perf_n[c] = '0;
            else if (m_start[c] && !done_in[c])
                perf_n[c] = m_perf[c] + 32'd1;
            else
                perf_n[c] = m_perf[c];
        end
        @(posedge clk);
        #2;
        m_prev = m_start;
        m_clr  = clr_n;
        for (int c = 0; c < 2; c++)
            m_perf[c] = perf_n[c];
        if (we)
            model_write();
        m_init = !en;
        m_len  = len_n;
        m_rd   = rd_n;
        check_eq("rd_d_o", m_rd, rd_d_o);
        check_eq("init_rst_o", 32'(m_init), 32'(init_rst_o));
        check_eq("mwr_len_o", 32'(m_len), 32'(mwr_len_o));
        check_eq("mrd_done_clr_o", 32'(m_clr[MRD]), 32'(mrd_done_clr_o));
        check_eq("mwr_done_clr_o", 32'(m_clr[MWR]), 32'(mwr_done_clr_o));
        check_eq("mrd_start_o", 32'(m_start[MRD]), 32'(mrd_start_o));
        check_eq("mwr_start_o", 32'(m_start[MWR]), 32'(mwr_start_o));
        for (int c = 0; c < 2; c++) begin
            pfx = (c == MRD) ? "mrd" : "mwr";
            check_eq({pfx, "_addr_o"}, m_addr[c], addr_out[c]);
            check_eq({pfx, "_size_o"}, m_size[c], size_out[c]);
            check_eq({pfx, " upper address outputs"}, m_up[c],
                     {up_addr_out[c], 3'h0, pfd_out[c], en64_out[c], tc_out[c], 16'h0});
            check_eq({pfx, "_relaxed_order_o"}, 32'(m_rel[c]), 32'(relaxed_out[c]));
            check_eq({pfx, "_nosnoop_o"}, 32'(m_ns[c]), 32'(nosnoop_out[c]));
        end
    endtask

    task automatic write_reg(input logic [6:0] idx, input logic [31:0] val);
        a  = idx;
        we = 1'b1;
        d  = val;
        step();
        we = 1'b0;
    endtask

    task automatic read_reg(input logic [6:0] idx);
        a  = idx;
        we = 1'b0;
        step();
    endtask

    task automatic wait_done_clr(input int ch, input logic [6:0] perf_idx);
        int cycles;
        cycles = 0;
        while (((ch == MRD) ? mrd_done_clr_o : mwr_done_clr_o) !== 1'b1) begin
            if (cycles == 8)
                report_timeout("done clear pulse");
            else begin
                read_reg(perf_idx);
                cycles++;
            end
        end
    endtask

    initial begin
        logic [31:0] r;
        logic [6:0]  idx;
        logic [6:0]  perf_idx;
        int          n;
        seed      = 32'h2f33_45eb;
        test_name = "reset";
        rst_n     = 1'b0;
        en        = 1'b1;
        we        = 1'b0;
        a         = '0;
        d         = '0;
        mps       = '0;
        done_in   = '0;
        model_reset();
        repeat (8) @(posedge clk);
        #2;
        rst_n = 1'b1;

        // Whole map after reset
        for (int i = 0; i < 128; i++)
            read_reg(7'(i));

        test_name = "random_rw";
        for (int i = 0; i < 300; i++) begin
            r = $random(seed);
            case (r[2:0])
                3'd1:    idx = REG_MRD_SIZE;
                3'd2:    idx = REG_MWR_SIZE;
                3'd3:    idx = REG_MRD_ADDR;
                3'd4:    idx = REG_MWR_ADDR;
                3'd5:    idx = REG_MRD_UP;
                3'd6:    idx = REG_MWR_UP;
                default: idx = REG_CTRL;
            endcase
            done_in = r[4:3];
            write_reg(idx, $random(seed));
            read_reg(idx);
            read_reg(r[31:25]);     // Any index including reserved ones
        end

        test_name = "id_and_len";
        for (int i = 0; i < 40; i++) begin
            r   = $random(seed);
            en  = r[0] | r[1];
            mps = r[4:2];
            step();
            read_reg(REG_ID);
            read_reg(REG_LEN);
        end
        en = 1'b1;

        for (int ch = 0; ch < 2; ch++) begin
            test_name = "busy_count";
            perf_idx  = (ch == MRD) ? REG_MRD_PERF : REG_MWR_PERF;
            done_in   = '0;
            write_reg(REG_CTRL, 32'h0);
            repeat (4) read_reg(perf_idx);
            write_reg(REG_CTRL, (ch == MRD) ? 32'h0001_0000 : 32'h0000_0001);
            n = 5 + int'($unsigned($random(seed)) % 32'd30);
            repeat (n) read_reg(perf_idx);
            done_in[ch] = 1'b1;
            read_reg(REG_CTRL);
            check_eq("done bit", 32'd1, 32'(rd_d_o[(ch == MRD) ? 24 : 8]));
            read_reg(perf_idx);

            test_name = "done_clear";
            write_reg(REG_CTRL, 32'h0);   // Start falls here
            wait_done_clr(ch, perf_idx);
            read_reg(perf_idx);
            read_reg(perf_idx);
            check_eq("perf after clear", 32'h0, rd_d_o);
        end

        test_name = "enable_low";
        done_in = '0;
        write_reg(REG_CTRL, 32'h0001_0001);
        repeat (10) read_reg(REG_MRD_PERF);
        en = 1'b0;
        repeat (3) read_reg(REG_MRD_PERF);
        check_eq("mrd perf with enable low", 32'h0, rd_d_o);
        read_reg(REG_MWR_PERF);
        check_eq("mwr perf with enable low", 32'h0, rd_d_o);
        en = 1'b1;
        write_reg(REG_CTRL, 32'h0);
        repeat (4) read_reg(REG_CTRL);

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire
